// File: bus_pkg.sv
// fixed 32-bit address and data bus; the io view of an address assumes the fixed region layout
`default_nettype none

package bus_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;

	// hosts behind the arbiter
	localparam int host_count = 2;

	// io view of an address
	// region picks main memory or io, device picks a block inside io
	typedef struct packed {
		logic        region;
		logic [10:0] reserved;
		logic [3:0]  device;
		logic [15:0] offset;
	} bus_io_fields_t;

	// one bus address, read flat or as io fields
	typedef union packed {
		logic [addr_w-1:0] flat;
		bus_io_fields_t    io;
	} bus_addr_u;

endpackage

`default_nettype wire

// File: soc_map_pkg.sv
// address map constants only; memory sizes are fixed here and higher address bits alias
`default_nettype none

package soc_map_pkg;

	// region bit values
	localparam logic region_main = 1'b1;
	localparam logic region_io   = 1'b0;

	// main memory is 4096 words, index from address bits 13..2
	localparam int main_depth_bits = 12;
	// scratch is 1024 words, index from offset bits 11..2
	localparam int scratch_depth_bits = 10;

	// device codes inside the io region
	localparam logic [3:0] dev_scratch = 4'd0;
	localparam logic [3:0] dev_gpio    = 4'd1;

	// gpio byte offsets
	localparam logic [15:0] gpio_reg_led = 16'd0;
	localparam logic [15:0] gpio_reg_sw  = 16'd4;

	// pin widths
	localparam int led_w = 4;
	localparam int sw_w  = 2;

endpackage

`default_nettype wire

// File: word_ram.sv
// word access only, byte bits 1..0 ignored and bits above the index alias; contents undefined at reset
`default_nettype none

module word_ram #(
	parameter int depth_bits = 10
) (
	input  wire logic                       clk_mem,
	input  wire logic                       rst,
	input  wire logic [bus_pkg::addr_w-1:0] addr,
	input  wire logic [bus_pkg::data_w-1:0] wdata,
	input  wire logic                       we,
	input  wire logic                       rd,
	output logic      [bus_pkg::data_w-1:0] rdata,
	output logic                            ready
);

	logic [bus_pkg::data_w-1:0] mem [2**depth_bits];
	bus_pkg::bus_addr_u         a;
	logic [depth_bits-1:0]      idx;
	logic                       seen;
	logic                       first;

	assign a.flat = addr;
	assign idx    = a.flat[depth_bits+1:2];
	// strobe not yet answered
	assign first  = (we || rd) && !seen;

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			seen  <= 1'b0;
			ready <= 1'b0;
		end else begin
			seen  <= we || rd;
			ready <= first;
		end
	end

	always_ff @(posedge clk_mem) begin
		if (first && we)
			mem[idx] <= wdata;
		if (first && rd)
			rdata <= mem[idx];
	end

endmodule

`default_nettype wire

// File: gpio_port.sv
// led and switch registers only, no interrupt; switches need two cycles to settle through the flops
`default_nettype none

module gpio_port (
	input  wire logic                           clk_mem,
	input  wire logic                           rst,
	input  wire logic [bus_pkg::addr_w-1:0]     addr,
	input  wire logic [bus_pkg::data_w-1:0]     wdata,
	input  wire logic                           we,
	input  wire logic                           rd,
	output logic      [bus_pkg::data_w-1:0]     rdata,
	output logic                                ready,
	input  wire logic [soc_map_pkg::sw_w-1:0]   sw,
	output logic      [soc_map_pkg::led_w-1:0]  led
);

	bus_pkg::bus_addr_u              a;
	logic [soc_map_pkg::sw_w-1:0]    sw_meta;
	logic [soc_map_pkg::sw_w-1:0]    sw_sync;
	logic                            seen;
	logic                            first;

	assign a.flat = addr;
	assign first  = (we || rd) && !seen;

	// two-flop synchronizer for the switch pins
	always_ff @(posedge clk_mem) begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
	end

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			seen  <= 1'b0;
			ready <= 1'b0;
			led   <= '0;
		end else begin
			seen  <= we || rd;
			ready <= first;
			if (first && we && a.io.offset == soc_map_pkg::gpio_reg_led)
				led <= wdata[soc_map_pkg::led_w-1:0];
		end
	end

	// read data, zero-extended
	always_ff @(posedge clk_mem) begin
		if (first && rd) begin
			if (a.io.offset == soc_map_pkg::gpio_reg_led)
				rdata <= {{(bus_pkg::data_w-soc_map_pkg::led_w){1'b0}}, led};
			else if (a.io.offset == soc_map_pkg::gpio_reg_sw)
				rdata <= {{(bus_pkg::data_w-soc_map_pkg::sw_w){1'b0}}, sw_sync};
			else
				rdata <= '0;
		end
	end

endmodule

`default_nettype wire

// File: io_decoder.sv
// io region only; unmapped device codes answer zero in one cycle and drop writes
`default_nettype none

module io_decoder (
	input  wire logic                           clk_mem,
	input  wire logic                           rst,
	input  wire logic [bus_pkg::addr_w-1:0]     io_addr,
	input  wire logic [bus_pkg::data_w-1:0]     io_wdata,
	input  wire logic                           io_we,
	input  wire logic                           io_rd,
	output logic      [bus_pkg::data_w-1:0]     io_rdata,
	output logic                                io_ready,
	input  wire logic [soc_map_pkg::sw_w-1:0]   sw,
	output logic      [soc_map_pkg::led_w-1:0]  led
);

	bus_pkg::bus_addr_u               a;
	logic                             sel_scratch;
	logic                             sel_gpio;
	logic                             sel_none;
	logic [bus_pkg::data_w-1:0]       scratch_rdata;
	logic                             scratch_ready;
	logic [bus_pkg::data_w-1:0]       gpio_rdata;
	logic                             gpio_ready;
	logic                             none_strobe;
	logic                             none_seen;
	logic                             none_ready;

	assign a.flat      = io_addr;
	assign sel_scratch = (a.io.device == soc_map_pkg::dev_scratch);
	assign sel_gpio    = (a.io.device == soc_map_pkg::dev_gpio);
	assign sel_none    = !sel_scratch && !sel_gpio;

	word_ram #(
		.depth_bits(soc_map_pkg::scratch_depth_bits)
	) scratch_ram (
		.clk_mem(clk_mem),
		.rst(rst),
		.addr(io_addr),
		.wdata(io_wdata),
		.we(io_we && sel_scratch),
		.rd(io_rd && sel_scratch),
		.rdata(scratch_rdata),
		.ready(scratch_ready)
	);

	gpio_port gpio (
		.clk_mem(clk_mem),
		.rst(rst),
		.addr(io_addr),
		.wdata(io_wdata),
		.we(io_we && sel_gpio),
		.rd(io_rd && sel_gpio),
		.rdata(gpio_rdata),
		.ready(gpio_ready),
		.sw(sw),
		.led(led)
	);

	// responder for holes in the map
	assign none_strobe = (io_we || io_rd) && sel_none;

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			none_seen  <= 1'b0;
			none_ready <= 1'b0;
		end else begin
			none_seen  <= none_strobe;
			none_ready <= none_strobe && !none_seen;
		end
	end

	always_comb begin
		if (sel_scratch) begin
			io_rdata = scratch_rdata;
			io_ready = scratch_ready;
		end else if (sel_gpio) begin
			io_rdata = gpio_rdata;
			io_ready = gpio_ready;
		end else begin
			io_rdata = '0;
			io_ready = none_ready;
		end
	end

endmodule

`default_nettype wire

// File: region_decoder.sv
// purely combinational; requester must hold the address until ready so the answer mux stays put
`default_nettype none

module region_decoder (
	input  wire logic [bus_pkg::addr_w-1:0] bus_addr,
	input  wire logic [bus_pkg::data_w-1:0] bus_wdata,
	input  wire logic                       bus_we,
	input  wire logic                       bus_rd,
	output logic      [bus_pkg::data_w-1:0] bus_rdata,
	output logic                            bus_ready,
	output logic      [bus_pkg::addr_w-1:0] mem_addr,
	output logic      [bus_pkg::data_w-1:0] mem_wdata,
	output logic                            mem_we,
	output logic                            mem_rd,
	input  wire logic [bus_pkg::data_w-1:0] mem_rdata,
	input  wire logic                       mem_ready,
	output logic      [bus_pkg::addr_w-1:0] io_addr,
	output logic      [bus_pkg::data_w-1:0] io_wdata,
	output logic                            io_we,
	output logic                            io_rd,
	input  wire logic [bus_pkg::data_w-1:0] io_rdata,
	input  wire logic                       io_ready
);

	bus_pkg::bus_addr_u a;
	logic               sel_main;
	logic               sel_io;

	assign a.flat   = bus_addr;
	assign sel_main = (a.io.region == soc_map_pkg::region_main);
	assign sel_io   = (a.io.region == soc_map_pkg::region_io);

	assign mem_addr  = bus_addr;
	assign mem_wdata = bus_wdata;
	assign io_addr   = bus_addr;
	assign io_wdata  = bus_wdata;

	// strobes reach one side only
	assign mem_we = bus_we && sel_main;
	assign mem_rd = bus_rd && sel_main;
	assign io_we  = bus_we && sel_io;
	assign io_rd  = bus_rd && sel_io;

	assign bus_rdata = sel_main ? mem_rdata : io_rdata;
	assign bus_ready = sel_main ? mem_ready : io_ready;

endmodule

`default_nettype wire

// File: bus_arbiter.sv
// two hosts, fixed priority to host 0 on a tie only; a holder keeps the bus until it drops req
`default_nettype none

module bus_arbiter (
	input  wire logic                        clk_mem,
	input  wire logic                        rst,
	input  wire logic                        h0_req,
	output logic                             h0_gnt,
	input  wire logic [bus_pkg::addr_w-1:0]  h0_addr,
	input  wire logic [bus_pkg::data_w-1:0]  h0_wdata,
	input  wire logic                        h0_we,
	input  wire logic                        h0_rd,
	output logic      [bus_pkg::data_w-1:0]  h0_rdata,
	output logic                             h0_ready,
	input  wire logic                        h1_req,
	output logic                             h1_gnt,
	input  wire logic [bus_pkg::addr_w-1:0]  h1_addr,
	input  wire logic [bus_pkg::data_w-1:0]  h1_wdata,
	input  wire logic                        h1_we,
	input  wire logic                        h1_rd,
	output logic      [bus_pkg::data_w-1:0]  h1_rdata,
	output logic                             h1_ready,
	output logic      [bus_pkg::addr_w-1:0]  bus_addr,
	output logic      [bus_pkg::data_w-1:0]  bus_wdata,
	output logic                             bus_we,
	output logic                             bus_rd,
	input  wire logic [bus_pkg::data_w-1:0]  bus_rdata,
	input  wire logic                        bus_ready
);

	localparam int owner_w = $clog2(bus_pkg::host_count);

	logic               busy;
	logic [owner_w-1:0] owner;
	logic               owner_req;
	bus_pkg::bus_addr_u sel_addr;

	assign owner_req = (owner == owner_w'(0)) ? h0_req : h1_req;

	// ownership held from grant until the holder's req is seen low
	always_ff @(posedge clk_mem) begin
		if (rst) begin
			busy  <= 1'b0;
			owner <= owner_w'(0);
		end else if (!busy) begin
			if (h0_req || h1_req) begin
				busy  <= 1'b1;
				owner <= h0_req ? owner_w'(0) : owner_w'(1);
			end
		end else if (!owner_req) begin
			busy <= 1'b0;
		end
	end

	assign h0_gnt = busy && (owner == owner_w'(0));
	assign h1_gnt = busy && (owner == owner_w'(1));

	// shared bus follows the owner
	assign sel_addr.flat = h1_gnt ? h1_addr : h0_addr;
	assign bus_addr      = sel_addr.flat;
	assign bus_wdata     = h1_gnt ? h1_wdata : h0_wdata;
	// no strobes reach the bus without a grant
	assign bus_we = (h0_gnt && h0_we) || (h1_gnt && h1_we);
	assign bus_rd = (h0_gnt && h0_rd) || (h1_gnt && h1_rd);

	assign h0_rdata = h0_gnt ? bus_rdata : '0;
	assign h1_rdata = h1_gnt ? bus_rdata : '0;
	assign h0_ready = h0_gnt && bus_ready;
	assign h1_ready = h1_gnt && bus_ready;

endmodule

`default_nettype wire

// File: soc_fabric.sv
// memory fabric top; hosts must follow the req/gnt and one-shot ready rules, no error response
`default_nettype none

module soc_fabric (
	input  wire logic                           clk_mem,
	input  wire logic                           rst,
	input  wire logic                           h0_req,
	output logic                                h0_gnt,
	input  wire logic [bus_pkg::addr_w-1:0]     h0_addr,
	input  wire logic [bus_pkg::data_w-1:0]     h0_wdata,
	input  wire logic                           h0_we,
	input  wire logic                           h0_rd,
	output logic      [bus_pkg::data_w-1:0]     h0_rdata,
	output logic                                h0_ready,
	input  wire logic                           h1_req,
	output logic                                h1_gnt,
	input  wire logic [bus_pkg::addr_w-1:0]     h1_addr,
	input  wire logic [bus_pkg::data_w-1:0]     h1_wdata,
	input  wire logic                           h1_we,
	input  wire logic                           h1_rd,
	output logic      [bus_pkg::data_w-1:0]     h1_rdata,
	output logic                                h1_ready,
	input  wire logic [soc_map_pkg::sw_w-1:0]   sw,
	output logic      [soc_map_pkg::led_w-1:0]  led
);

	// arbiter to region decoder
	logic [bus_pkg::addr_w-1:0] bus_addr;
	logic [bus_pkg::data_w-1:0] bus_wdata;
	logic                       bus_we;
	logic                       bus_rd;
	logic [bus_pkg::data_w-1:0] bus_rdata;
	logic                       bus_ready;
	// main memory side
	logic [bus_pkg::addr_w-1:0] mem_addr;
	logic [bus_pkg::data_w-1:0] mem_wdata;
	logic                       mem_we;
	logic                       mem_rd;
	logic [bus_pkg::data_w-1:0] mem_rdata;
	logic                       mem_ready;
	// io side
	logic [bus_pkg::addr_w-1:0] io_addr;
	logic [bus_pkg::data_w-1:0] io_wdata;
	logic                       io_we;
	logic                       io_rd;
	logic [bus_pkg::data_w-1:0] io_rdata;
	logic                       io_ready;

	bus_arbiter arb (
		.clk_mem(clk_mem), .rst(rst),
		.h0_req(h0_req), .h0_gnt(h0_gnt), .h0_addr(h0_addr), .h0_wdata(h0_wdata),
		.h0_we(h0_we), .h0_rd(h0_rd), .h0_rdata(h0_rdata), .h0_ready(h0_ready),
		.h1_req(h1_req), .h1_gnt(h1_gnt), .h1_addr(h1_addr), .h1_wdata(h1_wdata),
		.h1_we(h1_we), .h1_rd(h1_rd), .h1_rdata(h1_rdata), .h1_ready(h1_ready),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_we(bus_we), .bus_rd(bus_rd),
		.bus_rdata(bus_rdata), .bus_ready(bus_ready)
	);

	region_decoder region (
		.bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_we(bus_we), .bus_rd(bus_rd),
		.bus_rdata(bus_rdata), .bus_ready(bus_ready),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_rd(mem_rd),
		.mem_rdata(mem_rdata), .mem_ready(mem_ready),
		.io_addr(io_addr), .io_wdata(io_wdata), .io_we(io_we), .io_rd(io_rd),
		.io_rdata(io_rdata), .io_ready(io_ready)
	);

	word_ram #(
		.depth_bits(soc_map_pkg::main_depth_bits)
	) main_ram (
		.clk_mem(clk_mem), .rst(rst),
		.addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rd(mem_rd),
		.rdata(mem_rdata), .ready(mem_ready)
	);

	io_decoder io (
		.clk_mem(clk_mem), .rst(rst),
		.io_addr(io_addr), .io_wdata(io_wdata), .io_we(io_we), .io_rd(io_rd),
		.io_rdata(io_rdata), .io_ready(io_ready),
		.sw(sw), .led(led)
	);

endmodule

`default_nettype wire

// File: tb_soc_fabric.sv
// directed testbench for soc_fabric; inputs change on the falling edge and every task starts on one
`default_nettype none

module tb_soc_fabric;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeout_cycles = 2000;

	logic clk_mem = 1'b0;
	logic rst;
	logic h0_req, h0_gnt, h0_we, h0_rd, h0_ready;
	logic h1_req, h1_gnt, h1_we, h1_rd, h1_ready;
	logic [bus_pkg::addr_w-1:0] h0_addr, h1_addr;
	logic [bus_pkg::data_w-1:0] h0_wdata, h0_rdata, h1_wdata, h1_rdata;
	logic [soc_map_pkg::sw_w-1:0] sw;
	logic [soc_map_pkg::led_w-1:0] led;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int cycle_count = 0;
	logic [31:0] lcg_state = 32'd87870;
	logic [31:0] main_data [16];
	logic [31:0] scratch_data [16];

	soc_fabric dut (
		.clk_mem(clk_mem), .rst(rst),
		.h0_req(h0_req), .h0_gnt(h0_gnt), .h0_addr(h0_addr), .h0_wdata(h0_wdata),
		.h0_we(h0_we), .h0_rd(h0_rd), .h0_rdata(h0_rdata), .h0_ready(h0_ready),
		.h1_req(h1_req), .h1_gnt(h1_gnt), .h1_addr(h1_addr), .h1_wdata(h1_wdata),
		.h1_we(h1_we), .h1_rd(h1_rd), .h1_rdata(h1_rdata), .h1_ready(h1_ready),
		.sw(sw), .led(led)
	);

	always #4 clk_mem = ~clk_mem;

	always @(posedge clk_mem) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// byte offset shared by the main and scratch tests
	function automatic logic [31:0] offset_of(input int i);
		return 32'(i) * 32'd64 + 32'd4;
	endfunction

	task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("[ERROR] %s actual %h expected %h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %s passed", name);
		else
			$display("test %s failed, %0d errors", name, errors - errors_before);
	endtask

	task automatic drive_host(input int host, input logic [31:0] addr, input logic [31:0] wdata,
			input logic we, input logic rd);
		if (host == 0) begin
			h0_addr = addr;
			h0_wdata = wdata;
			h0_we = we;
			h0_rd = rd;
		end else begin
			h1_addr = addr;
			h1_wdata = wdata;
			h1_we = we;
			h1_rd = rd;
		end
	endtask

	task automatic acquire(input int host);
		int n;
		logic gnt;
		n = 0;
		if (host == 0)
			h0_req = 1'b1;
		else
			h1_req = 1'b1;
		do begin
			@(negedge clk_mem);
			n++;
			gnt = (host == 0) ? h0_gnt : h1_gnt;
		end while (!gnt && n < 16);
		if (!gnt) begin
			$display("host %0d was never granted the bus", host);
			errors++;
		end
	endtask

	task automatic release_bus(input int host);
		if (host == 0)
			h0_req = 1'b0;
		else
			h1_req = 1'b0;
		@(negedge clk_mem);
	endtask

	// one access, ready expected one cycle after the strobe
	task automatic bus_access(input int host, input logic [31:0] addr, input logic [31:0] wdata,
			input logic we, output logic [31:0] rdata);
		int n;
		logic rdy;
		n = 0;
		drive_host(host, addr, wdata, we, !we);
		do begin
			@(negedge clk_mem);
			n++;
			rdy = (host == 0) ? h0_ready : h1_ready;
		end while (!rdy && n < 16);
		if (!rdy) begin
			$display("host %0d saw no ready for address %h", host, addr);
			errors++;
		end else begin
			check((host == 0) ? "h0_ready latency" : "h1_ready latency", 32'(n), 32'd1);
		end
		rdata = (host == 0) ? h0_rdata : h1_rdata;
		drive_host(host, addr, wdata, 1'b0, 1'b0);
		// target answers again only after it has sampled the strobe low
		@(negedge clk_mem);
	endtask

	task automatic write_word(input int host, input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(host, addr, data, 1'b1, unused);
	endtask

	task automatic read_word(input int host, input logic [31:0] addr, output logic [31:0] data);
		bus_access(host, addr, 32'd0, 1'b0, data);
	endtask

	task automatic test_reset_state();
		int e;
		e = errors;
		check("h0_gnt", 32'(h0_gnt), 32'd0);
		check("h1_gnt", 32'(h1_gnt), 32'd0);
		check("h0_ready", 32'(h0_ready), 32'd0);
		check("h1_ready", 32'(h1_ready), 32'd0);
		check("led", 32'(led), 32'd0);
		report_test("reset_state", e);
	endtask

	task automatic test_main_memory();
		int e;
		logic [31:0] r;
		e = errors;
		acquire(0);
		for (int i = 0; i < 16; i++) begin
			main_data[i] = lcg_next();
			write_word(0, 32'h8000_0000 | offset_of(i), main_data[i]);
		end
		for (int i = 0; i < 16; i++) begin
			read_word(0, 32'h8000_0000 | offset_of(i), r);
			check("h0_rdata", r, main_data[i]);
		end
		// bit 14 lies above the index, so this lands on word 3
		read_word(0, 32'h8000_4000 | offset_of(3), r);
		check("h0_rdata alias", r, main_data[3]);
		release_bus(0);
		report_test("main_memory", e);
	endtask

	task automatic test_scratch_isolation();
		int e;
		logic [31:0] r;
		e = errors;
		acquire(1);
		for (int i = 0; i < 16; i++) begin
			scratch_data[i] = lcg_next();
			write_word(1, offset_of(i), scratch_data[i]);
		end
		for (int i = 0; i < 16; i++) begin
			read_word(1, offset_of(i), r);
			check("h1_rdata scratch", r, scratch_data[i]);
			read_word(1, 32'h8000_0000 | offset_of(i), r);
			check("h1_rdata main", r, main_data[i]);
		end
		release_bus(1);
		report_test("scratch_isolation", e);
	endtask

	task automatic test_gpio_unmapped();
		int e;
		logic [31:0] d;
		logic [31:0] r;
		e = errors;
		d = lcg_next();
		acquire(0);
		write_word(0, 32'h0001_0000, d);
		check("led", 32'(led), {28'd0, d[3:0]});
		read_word(0, 32'h0001_0000, r);
		check("h0_rdata led", r, {28'd0, d[3:0]});
		sw = 2'b10;
		repeat (3) @(negedge clk_mem);
		read_word(0, 32'h0001_0004, r);
		check("h0_rdata sw", r, 32'd2);
		// device 5 has nothing behind it
		read_word(0, 32'h0005_0000, r);
		check("h0_rdata unmapped", r, 32'd0);
		release_bus(0);
		report_test("gpio_unmapped", e);
	endtask

	task automatic test_arbitration();
		int e;
		logic [31:0] d0;
		logic [31:0] d1;
		logic [31:0] r;
		e = errors;
		d0 = lcg_next();
		d1 = lcg_next();
		h0_req = 1'b1;
		h1_req = 1'b1;
		@(negedge clk_mem);
		check("h0_gnt", 32'(h0_gnt), 32'd1);
		check("h1_gnt", 32'(h1_gnt), 32'd0);
		write_word(0, 32'h8000_0800, d0);
		check("h1_gnt", 32'(h1_gnt), 32'd0);
		read_word(0, 32'h8000_0800, r);
		check("h0_rdata", r, d0);
		check("h1_gnt", 32'(h1_gnt), 32'd0);
		h0_req = 1'b0;
		@(negedge clk_mem);
		check("h1_gnt", 32'(h1_gnt), 32'd0);
		@(negedge clk_mem);
		check("h1_gnt", 32'(h1_gnt), 32'd1);
		write_word(1, 32'h8000_0804, d1);
		read_word(1, 32'h8000_0800, r);
		check("h1_rdata", r, d0);
		read_word(1, 32'h8000_0804, r);
		check("h1_rdata", r, d1);
		release_bus(1);
		report_test("arbitration", e);
	endtask

	initial begin
		rst = 1'b1;
		h0_req = 1'b0;
		h1_req = 1'b0;
		drive_host(0, 32'd0, 32'd0, 1'b0, 1'b0);
		drive_host(1, 32'd0, 32'd0, 1'b0, 1'b0);
		sw = '0;
		repeat (5) @(posedge clk_mem);
		@(negedge clk_mem);
		rst = 1'b0;
		test_reset_state();
		test_main_memory();
		test_scratch_isolation();
		test_gpio_unmapped();
		test_arbitration();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
bus_pkg.sv
soc_map_pkg.sv
word_ram.sv
gpio_port.sv
io_decoder.sv
region_decoder.sv
bus_arbiter.sv
soc_fabric.sv
tb_soc_fabric.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f all.f --top-module tb_soc_fabric -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
